// File: bench/invadersTb.sv
`timescale 1ns/10ps
`default_nettype none

module invadersTb;
    import gamePkg::*;

    localparam int H_ACTIVE     = 64;
    localparam int V_ACTIVE     = 48;
    localparam int H_TOTAL      = 80;
    localparam int V_TOTAL      = 56;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_LEN   = 6;
    localparam int V_SYNC_START = 50;
    localparam int V_SYNC_LEN   = 2;
    localparam int MOVE_STEP    = 2;
    localparam int MONSTER_ROWS = 2;
    localparam int MONSTER_COLS = 4;
    localparam int MARCH_PERIOD = 16;
    localparam int POINTS       = 10;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 10;
    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int FULL_SCORE      = POINTS * MONSTER_ROWS * MONSTER_COLS;
    localparam int SHIP_ROW        = V_ACTIVE - 4; // a line through the ship band.
    localparam int IDLE_FRAMES     = 4;
    localparam int PAUSE_FRAMES    = 4;
    localparam int TAIL_FRAMES     = 4;
    localparam int PAUSE_AFTER     = 20;
    localparam int MAX_PLAY_FRAMES = 150;
    localparam int RUN_FRAMES      = IDLE_FRAMES + PAUSE_FRAMES + TAIL_FRAMES + MAX_PLAY_FRAMES + 10;

    logic        clk;
    logic        rst;
    logic        start;
    logic        pause;
    logic        left;
    logic        right;
    logic        fire;
    rgb          vgaRgb;
    logic        hSync;
    logic        vSync;
    logic [15:0] score;
    logic        gameWon;
    logic        gameOver;

    int          tbX;         // raster position of the output seen at this edge.
    int          tbY;
    int          stillFrames;
    int          frameCount;
    int          errors;
    logic        holdStill;   // stimulus keeps the game frozen.
    logic [15:0] prevScore;
    rgb          prevRow [H_ACTIVE];
    rgb          rowRef;
    logic        inWindow;
    logic        stillValid;

    invadersTop #(
        .H_ACTIVE     (H_ACTIVE),
        .V_ACTIVE     (V_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .V_TOTAL      (V_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN),
        .MOVE_STEP    (MOVE_STEP),
        .MONSTER_ROWS (MONSTER_ROWS),
        .MONSTER_COLS (MONSTER_COLS),
        .MARCH_PERIOD (MARCH_PERIOD),
        .POINTS       (POINTS)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .pause    (pause),
        .left     (left),
        .right    (right),
        .fire     (fire),
        .vgaRgb   (vgaRgb),
        .hSync    (hSync),
        .vSync    (vSync),
        .score    (score),
        .gameWon  (gameWon),
        .gameOver (gameOver)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("CHECK FAILED %s at %0t: got %h, expected %h", name, $time, got, want);
        errors++;
    endtask

    task automatic reportEvent(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    function automatic logic isPaletteColor(input rgb c);
        return c == PLAYER_COLOR || c == MISSILE_COLOR || c == MONSTER_COLOR || c == BACK_COLOR;
    endfunction

    // active-low pulse of len positions starting at startPos.
    function automatic logic expectedSync(input int pos, input int startPos, input int len);
        return !(pos >= startPos && pos < startPos + len);
    endfunction

    task automatic stepCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic pauseGame(input int frames);
        pause     = 1'b1;
        holdStill = 1'b1;
        for (int f = 0; f < frames; f++) begin
            left  = f[0]; // alternating, so a ship at either edge could still move.
            right = !f[0];
            stepCycles(FRAME_CYCLES);
        end
        holdStill = 1'b0;
        pause     = 1'b0;
    endtask

    ////////////////////
    // raster tracking
    ////////////////////
    always @(posedge clk) begin
        if (rst) begin
            tbX         <= H_TOTAL - 1; // first output after reset is still blank.
            tbY         <= V_TOTAL - 1;
            prevScore   <= '0;
            stillFrames <= 0;
            frameCount  <= 0;
        end else begin
            prevScore <= score;
            if (tbX == H_TOTAL - 1) begin
                tbX <= 0;
                tbY <= (tbY == V_TOTAL - 1) ? 0 : tbY + 1;
            end else begin
                tbX <= tbX + 1;
            end
            if (tbY == SHIP_ROW && tbX < H_ACTIVE) begin
                prevRow[tbX] <= vgaRgb;
            end
            if (tbX == 0 && tbY == 0) begin
                frameCount  <= frameCount + 1;
                stillFrames <= holdStill ? stillFrames + 1 : 0;
            end
        end
    end

    assign inWindow   = (tbX < H_ACTIVE) && (tbY < V_ACTIVE);
    assign stillValid = holdStill && (stillFrames >= 2); // one whole frozen frame already shown.
    assign rowRef     = prevRow[(tbX < H_ACTIVE) ? tbX : 0];

    ////////////////////
    // checks
    ////////////////////
    resetFlags: assert property (@(posedge clk) $fell(rst) |-> !gameWon && !gameOver)
        else reportEvent("end flag raised straight after reset");
    resetScore: assert property (@(posedge clk) $fell(rst) |-> score == 16'd0)
        else reportMismatch("score", $sampled(score), 0);
    resetSync: assert property (@(posedge clk) $fell(rst) |-> hSync && vSync)
        else reportMismatch("{hSync,vSync}", $sampled({hSync, vSync}), 2'b11);

    hSyncLevel: assert property (@(posedge clk) disable iff (rst)
        hSync == expectedSync(tbX, H_SYNC_START, H_SYNC_LEN))
        else reportMismatch("hSync", $sampled(hSync),
                            expectedSync($sampled(tbX), H_SYNC_START, H_SYNC_LEN));
    vSyncLevel: assert property (@(posedge clk) disable iff (rst)
        vSync == expectedSync(tbY, V_SYNC_START, V_SYNC_LEN))
        else reportMismatch("vSync", $sampled(vSync),
                            expectedSync($sampled(tbY), V_SYNC_START, V_SYNC_LEN));

    blankBlack: assert property (@(posedge clk) disable iff (rst) !inWindow |-> vgaRgb == '0)
        else reportMismatch("vgaRgb blanked", $sampled(vgaRgb), 0);
    paletteOnly: assert property (@(posedge clk) disable iff (rst)
        inWindow |-> isPaletteColor(vgaRgb))
        else reportEvent("vgaRgb shows a colour outside the palette");

    frozenScore: assert property (@(posedge clk) disable iff (rst) stillValid |-> score == prevScore)
        else reportMismatch("score frozen", $sampled(score), $sampled(prevScore));
    frozenShipRow: assert property (@(posedge clk) disable iff (rst)
        stillValid && tbY == SHIP_ROW && tbX < H_ACTIVE |-> vgaRgb == rowRef)
        else reportMismatch("vgaRgb ship row", $sampled(vgaRgb), $sampled(rowRef));

    scoreSteps: assert property (@(posedge clk) disable iff (rst)
        score != prevScore |-> score == prevScore + 16'(POINTS))
        else reportMismatch("score step", $sampled(score), $sampled(prevScore) + POINTS);
    scoreCap: assert property (@(posedge clk) disable iff (rst) score <= 16'(FULL_SCORE))
        else reportMismatch("score cap", $sampled(score), FULL_SCORE);

    wonHolds: assert property (@(posedge clk) disable iff (rst) gameWon |=> gameWon)
        else reportEvent("gameWon dropped after the game was won");
    overHolds: assert property (@(posedge clk) disable iff (rst) gameOver |=> gameOver)
        else reportEvent("gameOver dropped after the game was lost");
    endExclusive: assert property (@(posedge clk) disable iff (rst) !(gameWon && gameOver))
        else reportEvent("gameWon and gameOver are high together");
    wonFullScore: assert property (@(posedge clk) disable iff (rst)
        $rose(gameWon) |-> score == 16'(FULL_SCORE))
        else reportMismatch("score at win", $sampled(score), FULL_SCORE);

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + RUN_FRAMES * FRAME_CYCLES));
        $display("watchdog expired before the game reached its end");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int   dir;
        int   hold;
        int   playFrames;
        logic paused;
        void'($urandom(32'h970c));
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        pause      = 1'b0;
        left       = 1'b0;
        right      = 1'b0;
        fire       = 1'b0;
        holdStill  = 1'b1; // nothing moves before start.
        errors     = 0;
        playFrames = 0;
        paused     = 1'b0;
        stepCycles(RESET_CYCLES);
        rst = 1'b0;

        right = 1'b1; // a live input that must not move the ship before start.
        stepCycles(IDLE_FRAMES * FRAME_CYCLES);
        holdStill = 1'b0;
        start     = 1'b1;
        stepCycles(1);
        start = 1'b0;

        while (!gameWon && !gameOver && playFrames < MAX_PLAY_FRAMES) begin
            if (!paused && playFrames >= PAUSE_AFTER) begin
                pauseGame(PAUSE_FRAMES);
                paused = 1'b1;
            end
            dir   = $urandom_range(0, 2);
            hold  = $urandom_range(1, 4);
            left  = (dir == 1);
            right = (dir == 2);
            fire  = ($urandom_range(0, 2) == 0);
            stepCycles(hold * FRAME_CYCLES);
            playFrames += hold;
        end
        left  = 1'b0;
        right = 1'b0;
        fire  = 1'b0;

        // the formation keeps marching, so the game has to end.
        while (!gameWon && !gameOver) begin
            stepCycles(1);
        end
        holdStill = 1'b1;
        stepCycles(TAIL_FRAMES * FRAME_CYCLES);

        $display("%0d frames scanned, %0d errors", frameCount, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/gamePkg.sv
hw/objectPort.sv
hw/pixelScan.sv
hw/player.sv
hw/monsters.sv
hw/hitDetection.sv
hw/gameController.sv
hw/videoArbiter.sv
hw/invadersTop.sv
bench/invadersTb.sv

// File: hw/gameController.sv
`timescale 1ns/10ps
`default_nettype none

module gameController (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              pause,
    input  logic              allDead,
    input  logic              reachedBottom,
    output gamePkg::gameState state,
    output logic              frameEnable,
    output logic              gameWon,
    output logic              gameOver
);
    import gamePkg::*;

    gameState nextState;

    always_comb begin
        nextState = state;
        unique case (state)
            IDLE: begin
                if (start) nextState = PLAY;
            end
            PLAY: begin
                if (allDead) begin
                    nextState = WON;    // a clean sweep beats a late landing.
                end else if (reachedBottom) begin
                    nextState = OVER;
                end else if (pause) begin
                    nextState = PAUSE;
                end
            end
            PAUSE: begin
                if (!pause) nextState = PLAY;
            end
            default: nextState = state; // won and over wait for reset.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    assign frameEnable = (state == PLAY);
    assign gameWon     = (state == WON);
    assign gameOver    = (state == OVER);

endmodule

`default_nettype wire

// File: hw/gamePkg.sv
`default_nettype none

package gamePkg;

    typedef logic [9:0] coordinate;
    typedef logic [7:0] rgb; // packed as rrr_ggg_bb.

    typedef enum logic [2:0] {
        IDLE,
        PLAY,
        PAUSE,
        WON,
        OVER
    } gameState;

    localparam int COLL_MISSILE_MONSTER = 0;
    localparam int COLL_MONSTER_PLAYER  = 1;
    localparam int COLL_MISSILE_BORDER  = 2;
    localparam int NUM_COLLISIONS       = 3;

    typedef logic [NUM_COLLISIONS-1:0] collisionVec;

    ////////////////////
    // colours
    ////////////////////
    localparam rgb PLAYER_COLOR  = 8'b000_111_00;
    localparam rgb MISSILE_COLOR = 8'b111_111_00;
    localparam rgb MONSTER_COLOR = 8'b111_000_11;
    localparam rgb BACK_COLOR    = 8'b000_000_01; // kept nonzero so blanking stays visible.

    // arbiter priority follows the index, the lowest one wins.
    localparam int OBJ_PLAYER  = 0;
    localparam int OBJ_MISSILE = 1;
    localparam int OBJ_MONSTER = 2;
    localparam int NUM_OBJECTS = 3;

endpackage

`default_nettype wire

// File: hw/hitDetection.sv
`timescale 1ns/10ps
`default_nettype none

module hitDetection (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 startOfFrame,
    input  gamePkg::coordinate   pixelX,
    input  gamePkg::coordinate   pixelY,
    input  logic                 shipDraw,
    input  logic                 missileDraw,
    input  logic                 monsterDraw,
    output gamePkg::collisionVec collisions,
    output gamePkg::coordinate   hitX,
    output gamePkg::coordinate   hitY
);
    import gamePkg::*;

    collisionVec flags;     // sticky over the current frame.
    collisionVec pixelHits;

    always_comb begin
        pixelHits                       = '0;
        pixelHits[COLL_MISSILE_MONSTER] = missileDraw && monsterDraw;
        pixelHits[COLL_MONSTER_PLAYER]  = monsterDraw && shipDraw;
        pixelHits[COLL_MISSILE_BORDER]  = missileDraw && (pixelY == '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (startOfFrame) begin
            flags <= pixelHits; // pixel (0,0) already belongs to the new frame.
        end else begin
            flags <= flags | pixelHits;
        end
    end

    // keep only the first missile hit of each frame.
    always_ff @(posedge clk) begin
        if (pixelHits[COLL_MISSILE_MONSTER] && (startOfFrame || !flags[COLL_MISSILE_MONSTER])) begin
            hitX <= pixelX;
            hitY <= pixelY;
        end
    end

    assign collisions = startOfFrame ? flags : '0;

endmodule

`default_nettype wire

// File: hw/invadersTop.sv
`timescale 1ns/10ps
`default_nettype none

module invadersTop #(
    parameter int H_ACTIVE     = 64,
    parameter int V_ACTIVE     = 48,
    parameter int H_TOTAL      = 80,
    parameter int V_TOTAL      = 56,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_LEN   = 6,
    parameter int V_SYNC_START = 50,
    parameter int V_SYNC_LEN   = 2,
    parameter int MOVE_STEP    = 2,
    parameter int MONSTER_ROWS = 2,
    parameter int MONSTER_COLS = 4,
    parameter int MARCH_PERIOD = 16,
    parameter int POINTS       = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        pause,
    input  logic        left,
    input  logic        right,
    input  logic        fire,
    output gamePkg::rgb vgaRgb,
    output logic        hSync,
    output logic        vSync,
    output logic [15:0] score,
    output logic        gameWon,
    output logic        gameOver
);
    import gamePkg::*;

    localparam int PLAYER_Y = V_ACTIVE - 6; // top line of the ship band.

    coordinate   pixelX;
    coordinate   pixelY;
    logic        active;
    logic        startOfFrame;
    logic        rawHSync;
    logic        rawVSync;
    collisionVec collisions;
    coordinate   hitX;
    coordinate   hitY;
    logic        allDead;
    logic        reachedBottom;
    logic        frameEnable;

    objectPort objPorts [NUM_OBJECTS] ();

    for (genvar i = 0; i < NUM_OBJECTS; i++) begin : gPixel
        assign objPorts[i].pixelX = pixelX;
        assign objPorts[i].pixelY = pixelY;
    end

    pixelScan #(
        .H_ACTIVE     (H_ACTIVE),
        .V_ACTIVE     (V_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .V_TOTAL      (V_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) scan (
        .clk          (clk),
        .rst          (rst),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .active       (active),
        .startOfFrame (startOfFrame),
        .hSync        (rawHSync),
        .vSync        (rawVSync)
    );

    gameController ctrl (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .pause         (pause),
        .allDead       (allDead),
        .reachedBottom (reachedBottom),
        .state         (),
        .frameEnable   (frameEnable),
        .gameWon       (gameWon),
        .gameOver      (gameOver)
    );

    player #(
        .H_ACTIVE  (H_ACTIVE),
        .PLAYER_Y  (PLAYER_Y),
        .MOVE_STEP (MOVE_STEP)
    ) ship (
        .clk          (clk),
        .rst          (rst),
        .frameEnable  (frameEnable),
        .startOfFrame (startOfFrame),
        .collisions   (collisions),
        .left         (left),
        .right        (right),
        .fire         (fire),
        .ship         (objPorts[OBJ_PLAYER]),
        .missile      (objPorts[OBJ_MISSILE])
    );

    monsters #(
        .H_ACTIVE     (H_ACTIVE),
        .PLAYER_Y     (PLAYER_Y),
        .MONSTER_ROWS (MONSTER_ROWS),
        .MONSTER_COLS (MONSTER_COLS),
        .MARCH_PERIOD (MARCH_PERIOD),
        .POINTS       (POINTS)
    ) formation (
        .clk           (clk),
        .rst           (rst),
        .frameEnable   (frameEnable),
        .startOfFrame  (startOfFrame),
        .collisions    (collisions),
        .hitX          (hitX),
        .hitY          (hitY),
        .port          (objPorts[OBJ_MONSTER]),
        .allDead       (allDead),
        .reachedBottom (reachedBottom),
        .score         (score)
    );

    hitDetection hits (
        .clk          (clk),
        .rst          (rst),
        .startOfFrame (startOfFrame),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .shipDraw     (objPorts[OBJ_PLAYER].draw),
        .missileDraw  (objPorts[OBJ_MISSILE].draw),
        .monsterDraw  (objPorts[OBJ_MONSTER].draw),
        .collisions   (collisions),
        .hitX         (hitX),
        .hitY         (hitY)
    );

    videoArbiter video (
        .clk     (clk),
        .rst     (rst),
        .active  (active),
        .hSyncIn (rawHSync),
        .vSyncIn (rawVSync),
        .objects (objPorts),
        .vgaRgb  (vgaRgb),
        .hSync   (hSync),
        .vSync   (vSync)
    );

endmodule

`default_nettype wire

// File: hw/monsters.sv
`timescale 1ns/10ps
`default_nettype none

module monsters #(
    parameter int H_ACTIVE     = 64,
    parameter int PLAYER_Y     = 42,
    parameter int MONSTER_ROWS = 2,
    parameter int MONSTER_COLS = 4,
    parameter int MARCH_PERIOD = 16,
    parameter int POINTS       = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frameEnable,
    input  logic                 startOfFrame,
    input  gamePkg::collisionVec collisions,
    input  gamePkg::coordinate   hitX,
    input  gamePkg::coordinate   hitY,
    objectPort.render            port,
    output logic                 allDead,
    output logic                 reachedBottom,
    output logic [15:0]          score
);
    import gamePkg::*;

    localparam int CELL      = 8; // cell pitch in both directions.
    localparam int SPRITE_W  = 6;
    localparam int SPRITE_H  = 5;
    localparam int NUM_CELLS = MONSTER_ROWS * MONSTER_COLS;
    localparam int FORM_W    = MONSTER_COLS * CELL;
    localparam int FORM_H    = MONSTER_ROWS * CELL;
    localparam int FORM_X    = (H_ACTIVE - FORM_W) / 2;
    localparam int START_Y   = 2;
    localparam int MARCH_W   = $clog2(MARCH_PERIOD + 1);

    logic [NUM_CELLS-1:0] alive;
    coordinate            formY;
    coordinate            bottomY;
    coordinate            offX;
    coordinate            offY;
    logic [MARCH_W-1:0]   marchCount;
    logic                 frameTick;
    logic                 pixInside;
    logic                 hitInside;
    logic                 killHit;
    int                   pixCell;
    int                   hitCell;

    function automatic logic inFormation(coordinate x, coordinate y, coordinate top);
        return (x >= coordinate'(FORM_X)) && (x < coordinate'(FORM_X + FORM_W))
            && (y >= top) && (y < top + coordinate'(FORM_H));
    endfunction

    function automatic int cellOf(coordinate x, coordinate y, coordinate top);
        coordinate relX;
        coordinate relY;
        relX = x - coordinate'(FORM_X);
        relY = y - top;
        return int'(relY / CELL) * MONSTER_COLS + int'(relX / CELL);
    endfunction

    assign frameTick = startOfFrame && frameEnable;

    ////////////////////
    // rendering
    ////////////////////
    assign pixInside = inFormation(port.pixelX, port.pixelY, formY);
    assign pixCell   = cellOf(port.pixelX, port.pixelY, formY);
    assign offX      = port.pixelX - coordinate'(FORM_X);
    assign offY      = port.pixelY - formY;

    assign port.draw  = pixInside && alive[pixCell]
                     && (offX % CELL < SPRITE_W) && (offY % CELL < SPRITE_H);
    assign port.color = MONSTER_COLOR;

    // the hit was recorded against the formation as it stood last frame.
    assign hitInside = inFormation(hitX, hitY, formY);
    assign hitCell   = cellOf(hitX, hitY, formY);
    assign killHit   = collisions[COLL_MISSILE_MONSTER] && hitInside && alive[hitCell];

    always_comb begin
        bottomY = '0;
        for (int r = 0; r < MONSTER_ROWS; r++) begin
            if (|alive[r*MONSTER_COLS +: MONSTER_COLS]) begin
                bottomY = formY + coordinate'((r + 1) * CELL);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alive         <= '1;
            formY         <= coordinate'(START_Y);
            marchCount    <= '0;
            score         <= '0;
            reachedBottom <= 1'b0;
        end else if (frameTick) begin
            if (killHit) begin
                alive[hitCell] <= 1'b0;
                score          <= score + 16'(POINTS);
            end
            if (marchCount == MARCH_W'(MARCH_PERIOD - 1)) begin
                marchCount <= '0;
                formY      <= formY + coordinate'(CELL); // one cell down.
            end else begin
                marchCount <= marchCount + 1'b1;
            end
            if (bottomY > coordinate'(PLAYER_Y) || collisions[COLL_MONSTER_PLAYER]) begin
                reachedBottom <= 1'b1;
            end
        end
    end

    assign allDead = (alive == '0);

    // points are only awarded for exactly one monster removed.
    scoreFollowsKill: assert property (@(posedge clk) disable iff (rst)
        $changed(score) |-> $countones(alive) == $countones($past(alive)) - 1);

endmodule

`default_nettype wire

// File: hw/objectPort.sv
`timescale 1ns/10ps
`default_nettype none

interface objectPort;
    import gamePkg::*;

    coordinate pixelX;
    coordinate pixelY;
    logic      draw;   // the object covers the current pixel.
    rgb        color;

    modport render (
        input  pixelX,
        input  pixelY,
        output draw,
        output color
    );

    modport arbiter (
        input draw,
        input color
    );

endinterface

`default_nettype wire

// File: hw/pixelScan.sv
`timescale 1ns/10ps
`default_nettype none

module pixelScan #(
    parameter int H_ACTIVE     = 64,
    parameter int V_ACTIVE     = 48,
    parameter int H_TOTAL      = 80,
    parameter int V_TOTAL      = 56,
    parameter int H_SYNC_START = 68,
    parameter int H_SYNC_LEN   = 6,
    parameter int V_SYNC_START = 50,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic               clk,
    input  logic               rst,
    output gamePkg::coordinate pixelX,
    output gamePkg::coordinate pixelY,
    output logic               active,
    output logic               startOfFrame,
    output logic               hSync,
    output logic               vSync
);
    import gamePkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            pixelX <= '0;
            pixelY <= '0;
        end else if (pixelX == coordinate'(H_TOTAL - 1)) begin
            pixelX <= '0;
            pixelY <= (pixelY == coordinate'(V_TOTAL - 1)) ? '0 : pixelY + 1'b1;
        end else begin
            pixelX <= pixelX + 1'b1;
        end
    end

    assign active       = (pixelX < coordinate'(H_ACTIVE)) && (pixelY < coordinate'(V_ACTIVE));
    assign startOfFrame = (pixelX == '0) && (pixelY == '0);

    // both syncs are active low.
    assign hSync = !((pixelX >= coordinate'(H_SYNC_START))
                  && (pixelX < coordinate'(H_SYNC_START + H_SYNC_LEN)));
    assign vSync = !((pixelY >= coordinate'(V_SYNC_START))
                  && (pixelY < coordinate'(V_SYNC_START + V_SYNC_LEN)));

    // every frame pulse closes a full sweep of the previous frame.
    framePulseAtOrigin: assert property (@(posedge clk) disable iff (rst)
        startOfFrame && $past(!rst) |-> $past(pixelX) == coordinate'(H_TOTAL - 1)
                                     && $past(pixelY) == coordinate'(V_TOTAL - 1));

endmodule

`default_nettype wire

// File: hw/player.sv
`timescale 1ns/10ps
`default_nettype none

module player #(
    parameter int H_ACTIVE  = 64,
    parameter int PLAYER_Y  = 42,
    parameter int MOVE_STEP = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frameEnable,
    input  logic                 startOfFrame,
    input  gamePkg::collisionVec collisions,
    input  logic                 left,
    input  logic                 right,
    input  logic                 fire,
    objectPort.render            ship,
    objectPort.render            missile
);
    import gamePkg::*;

    localparam int SHIP_W        = 8;
    localparam int SHIP_H        = 4;
    localparam int MISSILE_H     = 3;
    localparam int MISSILE_SPEED = 2;

    localparam coordinate MAX_X = coordinate'(H_ACTIVE - SHIP_W);
    localparam coordinate STEP  = coordinate'(MOVE_STEP);

    coordinate shipX;
    coordinate missileX;
    coordinate missileY;
    logic      inFlight;
    logic      frameTick;

    assign frameTick = startOfFrame && frameEnable;

    always_ff @(posedge clk) begin
        if (rst) begin
            shipX <= coordinate'((H_ACTIVE - SHIP_W) / 2);
        end else if (frameTick) begin
            if (left && !right) begin
                shipX <= (shipX > STEP) ? shipX - STEP : '0;
            end else if (right && !left) begin
                shipX <= (shipX + STEP < MAX_X) ? shipX + STEP : MAX_X;
            end
        end
    end

    ////////////////////
    // missile
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= 1'b0;
        end else if (frameTick) begin
            if (inFlight) begin
                inFlight <= !(collisions[COLL_MISSILE_MONSTER] || collisions[COLL_MISSILE_BORDER]);
            end else begin
                inFlight <= fire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frameTick) begin
            if (!inFlight) begin
                missileX <= shipX + coordinate'(SHIP_W / 2); // parked on the nose until fired.
                missileY <= coordinate'(PLAYER_Y - MISSILE_H);
            end else begin
                missileY <= (missileY > coordinate'(MISSILE_SPEED))
                          ? missileY - coordinate'(MISSILE_SPEED) : '0;
            end
        end
    end

    assign ship.draw  = (ship.pixelX >= shipX) && (ship.pixelX < shipX + coordinate'(SHIP_W))
                     && (ship.pixelY >= coordinate'(PLAYER_Y))
                     && (ship.pixelY < coordinate'(PLAYER_Y + SHIP_H));
    assign ship.color = PLAYER_COLOR;

    assign missile.draw  = inFlight && (missile.pixelX == missileX)
                        && (missile.pixelY >= missileY)
                        && (missile.pixelY < missileY + coordinate'(MISSILE_H));
    assign missile.color = MISSILE_COLOR;

    // the ship moves only on an enabled frame and always lands inside the screen.
    shipInBounds: assert property (@(posedge clk) disable iff (rst)
        $changed(shipX) |-> $past(frameTick) && shipX <= MAX_X);

endmodule

`default_nettype wire

// File: hw/videoArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module videoArbiter (
    input  logic        clk,
    input  logic        rst,
    input  logic        active,
    input  logic        hSyncIn,
    input  logic        vSyncIn,
    objectPort.arbiter  objects [gamePkg::NUM_OBJECTS],
    output gamePkg::rgb vgaRgb,
    output logic        hSync,
    output logic        vSync
);
    import gamePkg::*;

    logic [NUM_OBJECTS-1:0] draws;
    rgb                     colors [NUM_OBJECTS];
    rgb                     pixel;

    for (genvar i = 0; i < NUM_OBJECTS; i++) begin : gUnpack
        assign draws[i]  = objects[i].draw;
        assign colors[i] = objects[i].color;
    end

    always_comb begin
        pixel = BACK_COLOR;
        for (int i = NUM_OBJECTS - 1; i >= 0; i--) begin
            if (draws[i]) pixel = colors[i]; // walking down leaves the lowest index on top.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vgaRgb <= '0;
            hSync  <= 1'b1;
            vSync  <= 1'b1;
        end else begin
            vgaRgb <= active ? pixel : '0;
            hSync  <= hSyncIn;
            vSync  <= vSyncIn;
        end
    end

    // sync pulses lie inside the blanking interval.
    blankedIsBlack: assert property (@(posedge clk) disable iff (rst)
        !(hSync && vSync) |-> vgaRgb == '0);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message.
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
        --top-module invadersTb -f build.f -o invadersSim \
    && ./obj_dir/invadersSim 2>&1 | tee sim.log \
    && ! grep -qF '*** FAILED ***' sim.log \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
